// File: design/rv_core.sv
`default_nettype none

module rv_core #(
  parameter rv_pkg::word_t reset_address = 32'h0000_0000
) (
  input  logic                 clock,
  input  logic                 reset,
  output rv_pkg::word_t        pc,
  input  rv_pkg::word_t        instruction,
  output rv_pkg::wb_request_t  bus_request,
  input  rv_pkg::wb_response_t bus_response,
  output logic                 halted,
  input  rv_pkg::reg_index_t   debug_index,
  output rv_pkg::word_t        debug_value
);
  import rv_pkg::*;

  reg_index_t rs1_index;
  reg_index_t rs2_index;
  word_t      rs1_value;
  word_t      rs2_value;
  decoded_t   decoded;
  executed_t  executed;
  reg_write_t write;
  logic       stall;
  reg_index_t execute_rd;
  logic       execute_writes;
  logic       execute_busy;
  reg_index_t memory_rd;
  logic       memory_writes;
  logic       memory_busy;

  rv_decode_stage #(
    .reset_address(reset_address)
  ) decode_i (
    .clock,
    .reset,
    .pc,
    .instruction,
    .rs1_index,
    .rs2_index,
    .rs1_value,
    .rs2_value,
    .stall,
    .execute_rd,
    .execute_writes,
    .memory_rd,
    .memory_writes,
    .decoded,
    .halted,
    .execute_busy,
    .memory_busy
  );

  rv_execute_stage execute_i (
    .clock,
    .reset,
    .decoded,
    .stall,
    .executed,
    .execute_rd,
    .execute_writes,
    .execute_busy
  );

  // bus master and writeback
  rv_memory_stage memory_i (
    .clock,
    .reset,
    .executed,
    .bus_request,
    .bus_response,
    .stall,
    .write,
    .memory_rd,
    .memory_writes,
    .memory_busy
  );

  rv_register_file register_file_i (
    .clock,
    .reset,
    .rs1_index,
    .rs2_index,
    .rs1_value,
    .rs2_value,
    .write,
    .debug_index,
    .debug_value
  );

endmodule

`default_nettype wire

// File: design/rv_decode_stage.sv
`default_nettype none

module rv_decode_stage #(
  parameter rv_pkg::word_t reset_address = 32'h0000_0000
) (
  input  logic               clock,
  input  logic               reset,
  output rv_pkg::word_t      pc,
  input  rv_pkg::word_t      instruction,
  output rv_pkg::reg_index_t rs1_index,
  output rv_pkg::reg_index_t rs2_index,
  input  rv_pkg::word_t      rs1_value,
  input  rv_pkg::word_t      rs2_value,
  input  logic               stall,
  input  rv_pkg::reg_index_t execute_rd,
  input  logic               execute_writes,
  input  rv_pkg::reg_index_t memory_rd,
  input  logic               memory_writes,
  output rv_pkg::decoded_t   decoded,
  output logic               halted,
  input  logic               execute_busy,
  input  logic               memory_busy
);
  import rv_pkg::*;

  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_lui    = 7'b0110111;
  localparam logic [6:0] opcode_auipc  = 7'b0010111;
  localparam logic [6:0] opcode_load   = 7'b0000011;
  localparam logic [6:0] opcode_store  = 7'b0100011;
  localparam word_t      ebreak_word   = 32'h0010_0073;

  logic [6:0] opcode;
  logic [2:0] funct3;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_u;
  logic       uses_rs1;
  logic       uses_rs2;
  logic       legal;
  logic       is_ebreak;
  logic       hazard;
  logic       issue;
  logic       halt_seen;
  decoded_t   next_decoded;

  // funct3 to alu op, alternate is instruction bit 30 where it matters
  function automatic alu_op_e alu_function(input logic [2:0] f3, input logic alternate);
    case (f3)
      3'b000:  return alternate ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alternate ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign opcode    = instruction[6:0];
  assign funct3    = instruction[14:12];
  assign rs1_index = instruction[19:15];
  assign rs2_index = instruction[24:20];
  assign imm_i     = {{20{instruction[31]}}, instruction[31:20]};
  assign imm_s     = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
  assign imm_u     = {instruction[31:12], 12'h000};
  assign is_ebreak = instruction == ebreak_word;

  always_comb begin
    next_decoded            = '0;
    next_decoded.alu_op     = alu_add;
    next_decoded.mem_op     = mem_none;
    next_decoded.operand_a  = rs1_value;
    next_decoded.store_data = rs2_value;
    next_decoded.rd         = instruction[11:7];
    uses_rs1                = 1'b0;
    uses_rs2                = 1'b0;
    legal                   = 1'b0;
    case (opcode)
      opcode_op: begin
        legal                  = 1'b1;
        uses_rs1               = 1'b1;
        uses_rs2               = 1'b1;
        next_decoded.operand_b = rs2_value;
        next_decoded.alu_op    = alu_function(funct3, instruction[30]);
        next_decoded.writes_rd = 1'b1;
      end
      opcode_op_imm: begin
        legal                  = 1'b1;
        uses_rs1               = 1'b1;
        next_decoded.operand_b = imm_i;
        // bit 30 is part of the immediate except for srai
        next_decoded.alu_op    = alu_function(funct3, funct3 == 3'b101 && instruction[30]);
        next_decoded.writes_rd = 1'b1;
      end
      opcode_lui: begin
        legal                  = 1'b1;
        next_decoded.operand_b = imm_u;
        next_decoded.alu_op    = alu_pass_b;
        next_decoded.writes_rd = 1'b1;
      end
      opcode_auipc: begin
        legal                  = 1'b1;
        next_decoded.operand_a = pc;
        next_decoded.operand_b = imm_u;
        next_decoded.writes_rd = 1'b1;
      end
      opcode_load: begin
        uses_rs1               = 1'b1;
        next_decoded.operand_b = imm_i;
        next_decoded.writes_rd = 1'b1;
        legal                  = 1'b1;
        case (funct3)
          3'b000:  next_decoded.mem_op = mem_lb;
          3'b001:  next_decoded.mem_op = mem_lh;
          3'b010:  next_decoded.mem_op = mem_lw;
          3'b100:  next_decoded.mem_op = mem_lbu;
          3'b101:  next_decoded.mem_op = mem_lhu;
          default: legal = 1'b0;
        endcase
      end
      opcode_store: begin
        uses_rs1               = 1'b1;
        uses_rs2               = 1'b1;
        next_decoded.operand_b = imm_s;
        legal                  = 1'b1;
        case (funct3)
          3'b000:  next_decoded.mem_op = mem_sb;
          3'b001:  next_decoded.mem_op = mem_sh;
          3'b010:  next_decoded.mem_op = mem_sw;
          default: legal = 1'b0;
        endcase
      end
      default: ;
    endcase
    // writes to x0 are dropped here so they never hold up the interlock
    next_decoded.writes_rd = next_decoded.writes_rd && next_decoded.rd != '0;
    next_decoded.valid     = legal && issue;
  end

  // source still waiting for a result in execute or memory
  assign hazard =
    (uses_rs1 && rs1_index != '0 &&
      ((execute_writes && execute_rd == rs1_index) ||
       (memory_writes && memory_rd == rs1_index))) ||
    (uses_rs2 && rs2_index != '0 &&
      ((execute_writes && execute_rd == rs2_index) ||
       (memory_writes && memory_rd == rs2_index)));

  assign issue = !halt_seen && !hazard;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      pc        <= reset_address;
      decoded   <= '0;
      halt_seen <= 1'b0;
      halted    <= 1'b0;
    end else begin
      if (!stall) begin
        // a hazard leaves a bubble in the slot and keeps pc
        decoded <= next_decoded;
        if (issue && !is_ebreak) begin
          pc <= pc + 32'd4;
        end
        if (is_ebreak) begin
          halt_seen <= 1'b1;
        end
      end
      // wait for older instructions to drain
      if (halt_seen && !execute_busy && !memory_busy) begin
        halted <= 1'b1;
      end
    end
  end

  store_never_writes_rd: assert property (
    @(posedge clock) disable iff (reset)
    decoded.valid && decoded.mem_op inside {mem_sb, mem_sh, mem_sw} |-> !decoded.writes_rd
  ) else $error("store in execute slot marked as writing rd");

endmodule

`default_nettype wire

// File: design/rv_execute_stage.sv
`default_nettype none

module rv_execute_stage (
  input  logic               clock,
  input  logic               reset,
  input  rv_pkg::decoded_t   decoded,
  input  logic               stall,
  output rv_pkg::executed_t  executed,
  output rv_pkg::reg_index_t execute_rd,
  output logic               execute_writes,
  output logic               execute_busy
);
  import rv_pkg::*;

  word_t      operand_a;
  word_t      operand_b;
  logic [4:0] shift_amount;
  word_t      alu_result;
  executed_t  next_executed;

  assign operand_a    = decoded.operand_a;
  assign operand_b    = decoded.operand_b;
  assign shift_amount = operand_b[4:0];

  // loads and stores decode to add, so the sum is the effective address
  always_comb begin
    case (decoded.alu_op)
      alu_add:    alu_result = operand_a + operand_b;
      alu_sub:    alu_result = operand_a - operand_b;
      alu_and:    alu_result = operand_a & operand_b;
      alu_or:     alu_result = operand_a | operand_b;
      alu_xor:    alu_result = operand_a ^ operand_b;
      alu_sll:    alu_result = operand_a << shift_amount;
      alu_srl:    alu_result = operand_a >> shift_amount;
      alu_sra:    alu_result = word_t'($signed(operand_a) >>> shift_amount);
      alu_slt:    alu_result = {31'b0, $signed(operand_a) < $signed(operand_b)};
      alu_sltu:   alu_result = {31'b0, operand_a < operand_b};
      alu_pass_b: alu_result = operand_b;
      default:    alu_result = '0;
    endcase
  end

  always_comb begin
    next_executed.valid      = decoded.valid;
    next_executed.result     = alu_result;
    next_executed.store_data = decoded.store_data;
    next_executed.mem_op     = decoded.mem_op;
    next_executed.rd         = decoded.rd;
    next_executed.writes_rd  = decoded.writes_rd;
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      executed <= '0;
    end else if (!stall) begin
      executed <= next_executed;
    end
  end

  // interlock view of the slot
  assign execute_rd     = decoded.rd;
  assign execute_writes = decoded.valid && decoded.writes_rd;
  assign execute_busy   = decoded.valid;

endmodule

`default_nettype wire

// File: design/rv_memory_stage.sv
`default_nettype none

module rv_memory_stage (
  input  logic                 clock,
  input  logic                 reset,
  input  rv_pkg::executed_t    executed,
  output rv_pkg::wb_request_t  bus_request,
  input  rv_pkg::wb_response_t bus_response,
  output logic                 stall,
  output rv_pkg::reg_write_t   write,
  output rv_pkg::reg_index_t   memory_rd,
  output logic                 memory_writes,
  output logic                 memory_busy
);
  import rv_pkg::*;

  logic       is_load;
  logic       is_store;
  logic       access;
  logic [1:0] byte_offset;
  word_t      lane_data;
  word_t      load_value;

  assign is_load = executed.valid &&
    executed.mem_op inside {mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu};
  assign is_store = executed.valid &&
    executed.mem_op inside {mem_sb, mem_sh, mem_sw};
  assign access      = is_load || is_store;
  assign byte_offset = executed.result[1:0];

  // request comes straight from the slot, which holds while stall is high
  always_comb begin
    bus_request.cyc = access;
    bus_request.stb = access;
    bus_request.we  = is_store;
    bus_request.adr = {executed.result[31:2], 2'b00};
    case (executed.mem_op)
      mem_lb, mem_lbu, mem_sb: begin
        bus_request.sel = byte_sel_t'(4'b0001 << byte_offset);
        bus_request.dat = {4{executed.store_data[7:0]}};
      end
      mem_lh, mem_lhu, mem_sh: begin
        bus_request.sel = byte_offset[1] ? 4'b1100 : 4'b0011;
        bus_request.dat = {2{executed.store_data[15:0]}};
      end
      default: begin
        bus_request.sel = 4'b1111;
        bus_request.dat = executed.store_data;
      end
    endcase
  end

  // addressed byte or halfword moved down to lane 0
  assign lane_data = bus_response.dat >> {byte_offset, 3'b000};

  always_comb begin
    case (executed.mem_op)
      mem_lb:  load_value = {{24{lane_data[7]}}, lane_data[7:0]};
      mem_lbu: load_value = {24'b0, lane_data[7:0]};
      mem_lh:  load_value = {{16{lane_data[15]}}, lane_data[15:0]};
      mem_lhu: load_value = {16'b0, lane_data[15:0]};
      default: load_value = bus_response.dat;
    endcase
  end

  assign stall = access && !bus_response.ack;

  // alu results retire in the slot's cycle, loads on the ack edge
  always_comb begin
    write.enable = executed.valid && executed.writes_rd && (!is_load || bus_response.ack);
    write.index  = executed.rd;
    write.data   = is_load ? load_value : executed.result;
  end

  assign memory_rd     = executed.rd;
  assign memory_writes = executed.valid && executed.writes_rd;
  assign memory_busy   = executed.valid;

  // the slave answers only a strobed cycle
  ack_within_strobe: assert property (
    @(posedge clock) disable iff (reset)
    bus_response.ack |-> bus_request.cyc && bus_request.stb
  ) else $error("wishbone ack without an active cyc and stb");

  request_held_until_ack: assert property (
    @(posedge clock) disable iff (reset)
    bus_request.cyc && !bus_response.ack |=> $stable(bus_request)
  ) else $error("wishbone request changed before ack");

endmodule

`default_nettype wire

// File: design/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // data word, address and pc
  typedef logic [31:0] word_t;

  // architectural register number
  typedef logic [4:0] reg_index_t;

  // one bit per byte lane of a bus word
  typedef logic [3:0] byte_sel_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    // lui passes the shifted immediate through
    alu_pass_b
  } alu_op_e;

  typedef enum logic [3:0] {
    mem_none,
    mem_lb,
    mem_lh,
    mem_lw,
    mem_lbu,
    mem_lhu,
    mem_sb,
    mem_sh,
    mem_sw
  } mem_op_e;

  // decode to execute slot
  typedef struct packed {
    logic       valid;
    alu_op_e    alu_op;
    word_t      operand_a;
    word_t      operand_b;
    word_t      store_data;
    mem_op_e    mem_op;
    reg_index_t rd;
    logic       writes_rd;
  } decoded_t;

  // execute to memory slot, result is the effective address for loads and stores
  typedef struct packed {
    logic       valid;
    word_t      result;
    word_t      store_data;
    mem_op_e    mem_op;
    reg_index_t rd;
    logic       writes_rd;
  } executed_t;

  // wishbone classic, master to slave
  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    word_t     adr;
    word_t     dat;
    byte_sel_t sel;
  } wb_request_t;

  // wishbone classic, slave to master
  typedef struct packed {
    word_t dat;
    logic  ack;
  } wb_response_t;

  typedef struct packed {
    logic       enable;
    reg_index_t index;
    word_t      data;
  } reg_write_t;

endpackage

`default_nettype wire

// File: design/rv_register_file.sv
`default_nettype none

module rv_register_file (
  input  logic               clock,
  input  logic               reset,
  input  rv_pkg::reg_index_t rs1_index,
  input  rv_pkg::reg_index_t rs2_index,
  output rv_pkg::word_t      rs1_value,
  output rv_pkg::word_t      rs2_value,
  input  rv_pkg::reg_write_t write,
  input  rv_pkg::reg_index_t debug_index,
  output rv_pkg::word_t      debug_value
);
  import rv_pkg::*;

  // x0 has no storage
  word_t registers [1:31];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        registers[i] <= '0;
      end
    end else if (write.enable && write.index != '0) begin
      registers[write.index] <= write.data;
    end
  end

  // no write-through, decode reads the new value one cycle after the edge
  always_comb begin
    rs1_value = (rs1_index == '0) ? '0 : registers[rs1_index];
    rs2_value = (rs2_index == '0) ? '0 : registers[rs2_index];
  end

  // debug read-out for the environment
  always_comb begin
    debug_value = (debug_index == '0) ? '0 : registers[debug_index];
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module rv_core_tb -f rv_core.f -o rv_core_sim \
  && ./obj_dir/rv_core_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: rv_core.f
design/rv_pkg.sv
design/rv_register_file.sv
design/rv_decode_stage.sv
design/rv_execute_stage.sv
design/rv_memory_stage.sv
design/rv_core.sv
verification/wb_memory_model.sv
verification/rv_core_tb.sv

// File: verification/rv_core_tb.sv
`default_nettype none

module rv_core_tb;
  timeunit 1ns;
  timeprecision 1ns;
  import rv_pkg::*;

  localparam word_t reset_address = 32'h0000_0080;
  localparam int    random_seed   = 32'h619bda1b;
  localparam int    rom_words     = 256;
  localparam word_t ebreak_word   = 32'h0010_0073;

  localparam logic [6:0] op_imm      = 7'b0010011;
  localparam logic [6:0] op_load     = 7'b0000011;
  localparam logic [6:0] op_lui      = 7'b0110111;
  localparam logic [6:0] op_auipc    = 7'b0010111;
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;

  typedef struct packed {
    reg_index_t index;
    word_t      value;
  } check_t;

  logic         clock = 1'b0;
  logic         reset;
  word_t        pc;
  word_t        instruction;
  wb_request_t  bus_request;
  wb_response_t bus_response;
  logic         halted;
  reg_index_t   debug_index;
  word_t        debug_value;

  word_t      program_q [$];
  check_t     checks_q [$];
  word_t      rom [rom_words];
  logic [7:0] rom_base;
  word_t      auipc_pc;
  word_t      halt_pc;
  int         lane_errors;
  int         errors = 0;
  int         cycles = 0;
  int         cycle_limit = 0;

  rv_core #(
    .reset_address(reset_address)
  ) dut_i (
    .clock,
    .reset,
    .pc,
    .instruction,
    .bus_request,
    .bus_response,
    .halted,
    .debug_index,
    .debug_value
  );

  wb_memory_model #(
    .random_seed(random_seed)
  ) memory_i (
    .clock,
    .reset,
    .request(bus_request),
    .response(bus_response),
    .lane_errors
  );

  always #50 clock = ~clock;

  // fetch answers in the same cycle
  assign instruction = rom[pc[9:2]];

  function automatic word_t r_type(input logic [6:0] funct7, input logic [2:0] funct3,
                                   input reg_index_t rd, input reg_index_t rs1,
                                   input reg_index_t rs2);
    return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
  endfunction

  function automatic word_t i_type(input logic [6:0] opcode, input logic [2:0] funct3,
                                   input reg_index_t rd, input reg_index_t rs1,
                                   input logic [11:0] imm);
    return {imm, rs1, funct3, rd, opcode};
  endfunction

  function automatic word_t s_type(input logic [2:0] funct3, input reg_index_t rs2,
                                   input reg_index_t rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, funct3, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t u_type(input logic [6:0] opcode, input reg_index_t rd,
                                   input logic [19:0] imm);
    return {imm, rd, opcode};
  endfunction

  function automatic check_t register_check(input reg_index_t index, input word_t value);
    return '{index, value};
  endfunction

  task automatic build_program();
    // x1 = 5, x2 = -3, then every register-register op on them
    program_q.push_back(i_type(op_imm, 3'b000, 5'd1, 5'd0, 12'h005));
    program_q.push_back(i_type(op_imm, 3'b000, 5'd2, 5'd0, 12'hffd));
    program_q.push_back(r_type(funct7_base, 3'b000, 5'd3, 5'd1, 5'd2));
    program_q.push_back(r_type(funct7_alt, 3'b000, 5'd4, 5'd1, 5'd2));
    program_q.push_back(r_type(funct7_base, 3'b111, 5'd5, 5'd1, 5'd2));
    program_q.push_back(r_type(funct7_base, 3'b110, 5'd6, 5'd1, 5'd2));
    program_q.push_back(r_type(funct7_base, 3'b100, 5'd7, 5'd1, 5'd2));
    program_q.push_back(r_type(funct7_base, 3'b001, 5'd8, 5'd1, 5'd1));
    program_q.push_back(r_type(funct7_base, 3'b101, 5'd9, 5'd2, 5'd1));
    program_q.push_back(r_type(funct7_alt, 3'b101, 5'd11, 5'd2, 5'd1));
    program_q.push_back(r_type(funct7_base, 3'b010, 5'd12, 5'd2, 5'd1));
    program_q.push_back(r_type(funct7_base, 3'b011, 5'd13, 5'd2, 5'd1));
    // immediate forms
    program_q.push_back(i_type(op_imm, 3'b010, 5'd14, 5'd2, 12'hffe));
    program_q.push_back(i_type(op_imm, 3'b011, 5'd15, 5'd1, 12'hfff));
    program_q.push_back(i_type(op_imm, 3'b100, 5'd16, 5'd1, 12'hfff));
    program_q.push_back(i_type(op_imm, 3'b101, 5'd17, 5'd2, 12'h401));
    program_q.push_back(i_type(op_imm, 3'b101, 5'd18, 5'd2, 12'h01c));
    program_q.push_back(i_type(op_imm, 3'b001, 5'd19, 5'd1, 12'h01e));
    program_q.push_back(i_type(op_imm, 3'b111, 5'd20, 5'd2, 12'h0f0));
    program_q.push_back(u_type(op_lui, 5'd21, 20'h12345));
    auipc_pc = reset_address + 32'd4 * 32'(program_q.size());
    program_q.push_back(u_type(op_auipc, 5'd22, 20'h00001));
    // write to x0, then a back-to-back dependent chain reading it
    program_q.push_back(i_type(op_imm, 3'b000, 5'd0, 5'd1, 12'h007));
    program_q.push_back(r_type(funct7_base, 3'b000, 5'd23, 5'd0, 5'd1));
    program_q.push_back(r_type(funct7_base, 3'b000, 5'd23, 5'd23, 5'd23));
    program_q.push_back(r_type(funct7_base, 3'b000, 5'd23, 5'd23, 5'd3));
    program_q.push_back(u_type(op_lui, 5'd24, 20'h80f17));
    program_q.push_back(i_type(op_imm, 3'b000, 5'd24, 5'd24, 12'h7e3));
    program_q.push_back(i_type(op_imm, 3'b000, 5'd10, 5'd0, 12'h200));
    // word, four bytes and two halfwords into three words at x10
    program_q.push_back(s_type(3'b010, 5'd24, 5'd10, 12'h000));
    program_q.push_back(s_type(3'b000, 5'd2, 5'd10, 12'h004));
    program_q.push_back(s_type(3'b000, 5'd1, 5'd10, 12'h005));
    program_q.push_back(s_type(3'b000, 5'd24, 5'd10, 12'h006));
    program_q.push_back(s_type(3'b000, 5'd8, 5'd10, 12'h007));
    program_q.push_back(s_type(3'b001, 5'd24, 5'd10, 12'h008));
    program_q.push_back(s_type(3'b001, 5'd2, 5'd10, 12'h00a));
    // load followed by a use of its result
    program_q.push_back(i_type(op_load, 3'b010, 5'd25, 5'd10, 12'h000));
    program_q.push_back(r_type(funct7_base, 3'b000, 5'd24, 5'd25, 5'd1));
    program_q.push_back(i_type(op_load, 3'b010, 5'd26, 5'd10, 12'h004));
    program_q.push_back(i_type(op_load, 3'b010, 5'd27, 5'd10, 12'h008));
    program_q.push_back(i_type(op_load, 3'b000, 5'd28, 5'd10, 12'h007));
    program_q.push_back(i_type(op_load, 3'b100, 5'd29, 5'd10, 12'h006));
    program_q.push_back(i_type(op_load, 3'b001, 5'd30, 5'd10, 12'h00a));
    program_q.push_back(i_type(op_load, 3'b101, 5'd31, 5'd10, 12'h00a));
    program_q.push_back(ebreak_word);
  endtask

  task automatic build_checks();
    checks_q.push_back(register_check(5'd0, 32'h0000_0000));
    checks_q.push_back(register_check(5'd1, 32'h0000_0005));
    checks_q.push_back(register_check(5'd2, 32'hffff_fffd));
    checks_q.push_back(register_check(5'd3, 32'h0000_0002));
    checks_q.push_back(register_check(5'd4, 32'h0000_0008));
    checks_q.push_back(register_check(5'd5, 32'h0000_0005));
    checks_q.push_back(register_check(5'd6, 32'hffff_fffd));
    checks_q.push_back(register_check(5'd7, 32'hffff_fff8));
    checks_q.push_back(register_check(5'd8, 32'h0000_00a0));
    checks_q.push_back(register_check(5'd9, 32'h07ff_ffff));
    checks_q.push_back(register_check(5'd10, 32'h0000_0200));
    checks_q.push_back(register_check(5'd11, 32'hffff_ffff));
    checks_q.push_back(register_check(5'd12, 32'h0000_0001));
    checks_q.push_back(register_check(5'd13, 32'h0000_0000));
    checks_q.push_back(register_check(5'd14, 32'h0000_0001));
    checks_q.push_back(register_check(5'd15, 32'h0000_0001));
    checks_q.push_back(register_check(5'd16, 32'hffff_fffa));
    checks_q.push_back(register_check(5'd17, 32'hffff_fffe));
    checks_q.push_back(register_check(5'd18, 32'h0000_000f));
    checks_q.push_back(register_check(5'd19, 32'h4000_0000));
    checks_q.push_back(register_check(5'd20, 32'h0000_00f0));
    checks_q.push_back(register_check(5'd21, 32'h1234_5000));
    checks_q.push_back(register_check(5'd22, auipc_pc + 32'h0000_1000));
    checks_q.push_back(register_check(5'd23, 32'h0000_000c));
    checks_q.push_back(register_check(5'd24, 32'h80f1_77e8));
    checks_q.push_back(register_check(5'd25, 32'h80f1_77e3));
    checks_q.push_back(register_check(5'd26, 32'ha0e3_05fd));
    checks_q.push_back(register_check(5'd27, 32'hfffd_77e3));
    checks_q.push_back(register_check(5'd28, 32'hffff_ffa0));
    checks_q.push_back(register_check(5'd29, 32'h0000_00e3));
    checks_q.push_back(register_check(5'd30, 32'hffff_fffd));
    checks_q.push_back(register_check(5'd31, 32'h0000_fffd));
  endtask

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the core did not halt and finish checks within %0d cycles",
               cycle_limit);
      $display("errors: %0d register, %0d bus lane", errors, lane_errors);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    reset       = 1'b1;
    debug_index = '0;
    build_program();
    build_checks();
    cycle_limit = program_q.size() * 8 + 50;
    rom_base    = reset_address[9:2];
    // words outside the program are nops that differ by address
    for (int i = 0; i < rom_words; i++) begin
      rom[i] = i_type(op_imm, 3'b000, 5'd0, 5'd0, 12'(i));
    end
    for (int i = 0; i < program_q.size(); i++) begin
      rom[rom_base + 8'(i)] = program_q[i];
    end
    repeat (3) @(posedge clock);
    #1 reset = 1'b0;

    @(posedge clock);
    #1;
    while (!halted) begin
      @(posedge clock);
      #1;
    end
    halt_pc = pc;
    if (halt_pc !== reset_address + 32'd4 * 32'(program_q.size() - 1)) begin
      errors++;
      $display("ERR %0t: pc %h at halt, expected the ebreak address", $time, halt_pc);
    end
    // pc frozen once halted
    repeat (10) begin
      @(posedge clock);
      #1;
      if (pc !== halt_pc || halted !== 1'b1) begin
        errors++;
        $display("ERR %0t: pc %h halted %b, expected pc %h held with halted high",
                 $time, pc, halted, halt_pc);
      end
    end

    foreach (checks_q[i]) begin
      @(posedge clock);
      #1 debug_index = checks_q[i].index;
      @(negedge clock);
      if (debug_value !== checks_q[i].value) begin
        errors++;
        $display("ERR %0t: x%0d reads %h, expected %h",
                 $time, checks_q[i].index, debug_value, checks_q[i].value);
      end
    end

    $display("errors: %0d register, %0d bus lane", errors, lane_errors);
    if (errors == 0 && lane_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/wb_memory_model.sv
`default_nettype none

module wb_memory_model #(
  parameter int random_seed = 1
) (
  input  logic                 clock,
  input  logic                 reset,
  input  rv_pkg::wb_request_t  request,
  output rv_pkg::wb_response_t response,
  output int                   lane_errors
);
  timeunit 1ns;
  timeprecision 1ns;
  import rv_pkg::*;

  localparam int words = 256;

  word_t      memory [words];
  logic [7:0] index;
  logic       waiting;
  logic [1:0] waits_left;
  logic [1:0] wait_count;
  integer     seed = random_seed;

  assign index = request.adr[9:2];

  // byte, aligned halfword or full word
  function automatic logic lanes_legal(input byte_sel_t sel);
    return sel inside {4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111};
  endfunction

  // zero to three wait states, drawn when a request first arrives
  always @(posedge clock or posedge reset) begin
    if (reset) begin
      response    <= '0;
      waiting     <= 1'b0;
      waits_left  <= '0;
      lane_errors <= 0;
      // fill varies with every address bit of the index
      for (int i = 0; i < words; i++) begin
        memory[i] <= 32'ha500_0000 ^ (i << 12) ^ i;
      end
    end else begin
      response.ack <= 1'b0;
      if (request.cyc && request.stb && !response.ack) begin
        if (waiting) begin
          wait_count = waits_left;
        end else begin
          wait_count = 2'($random(seed));
        end
        if (wait_count != '0) begin
          waiting    <= 1'b1;
          waits_left <= wait_count - 2'd1;
        end else begin
          waiting      <= 1'b0;
          response.ack <= 1'b1;
          if (!lanes_legal(request.sel)) begin
            $display("bus error at %0t: byte select %b at address %h is not a legal lane pattern",
                     $time, request.sel, request.adr);
            lane_errors <= lane_errors + 1;
          end
          if (request.we) begin
            for (int lane = 0; lane < 4; lane++) begin
              if (request.sel[lane]) begin
                memory[index][lane*8 +: 8] <= request.dat[lane*8 +: 8];
              end
            end
          end else begin
            response.dat <= memory[index];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire
